/* design/seg_consts.svh */
`ifndef SEG_CONSTS_SVH
`define SEG_CONSTS_SVH

// slot and port counts
`define SEG_NUM_SLOTS 6
`define SEG_NUM_PORTS 4

// slot address, wide enough for 8 codes
`define SEG_ADDR_W 3

// field widths of one slot
`define SEG_BASE_W 16
`define SEG_LIM_W 20
`define SEG_TAG_W 7

`endif

/* design/seg_types_pkg.sv */
`include "seg_consts.svh"

package seg_types_pkg;

    ////////////////////
    // stored slot state
    ////////////////////

    typedef struct packed {
        logic [`SEG_BASE_W-1:0] base;
        logic [`SEG_LIM_W-1:0]  limit;
        logic [`SEG_TAG_W-1:0]  tag;
        logic                   pending;
    } seg_state_t;

    ////////////////////
    // read port result
    ////////////////////

    // same fields as the stored state, zero for unused addresses
    typedef struct packed {
        logic [`SEG_BASE_W-1:0] base;
        logic [`SEG_LIM_W-1:0]  limit;
        logic [`SEG_TAG_W-1:0]  tag;
        logic                   pending;
    } seg_rd_t;

endpackage

/* design/seg_port_pkg.sv */
`include "seg_consts.svh"

package seg_port_pkg;

    ////////////////////
    // incoming requests
    ////////////////////

    typedef struct packed {
        logic                   valid;
        logic [`SEG_ADDR_W-1:0] addr;
        logic [`SEG_BASE_W-1:0] base;
    } seg_ld_req_t;

    // writeback of a completed instruction, by tag
    typedef struct packed {
        logic                  valid;
        logic [`SEG_TAG_W-1:0] tag;
    } seg_wb_t;

    ////////////////////
    // per-slot control
    ////////////////////

    typedef struct packed {
        logic                               ld;
        logic [$clog2(`SEG_NUM_PORTS)-1:0]  port;
        logic                               mark;
        logic                               tag_clr;
    } seg_slot_ctl_t;

endpackage

/* design/seg_ctrl.sv */
`include "seg_consts.svh"

module seg_ctrl
    import seg_port_pkg::*;
(
    input  logic                                        clr,
    input  seg_ld_req_t [`SEG_NUM_PORTS-1:0]            ld_req,
    input  logic [`SEG_NUM_PORTS-1:0][`SEG_ADDR_W-1:0]  rd_addr,
    input  logic [`SEG_NUM_PORTS-1:0]                   mark,
    input  seg_wb_t                                     wb,
    input  logic [`SEG_NUM_SLOTS-1:0][`SEG_TAG_W-1:0]  slot_tag,
    output seg_slot_ctl_t [`SEG_NUM_SLOTS-1:0]          slot_ctl,
    output logic                                        flush
);

    localparam int PORT_W = $clog2(`SEG_NUM_PORTS);

    // per slot, per port hit vectors
    logic [`SEG_NUM_SLOTS-1:0][`SEG_NUM_PORTS-1:0] ld_hit;
    logic [`SEG_NUM_SLOTS-1:0][`SEG_NUM_PORTS-1:0] mark_hit;

    ////////////////////
    // address decode
    ////////////////////

    always_comb begin
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                ld_hit[s][p]   = ld_req[p].valid && (ld_req[p].addr == `SEG_ADDR_W'(s));
                mark_hit[s][p] = mark[p] && (rd_addr[p] == `SEG_ADDR_W'(s));
            end
        end
    end

    ////////////////////
    // per-slot control
    ////////////////////

    always_comb begin
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            slot_ctl[s] = '0;

            // later ports overwrite, so the highest valid port wins
            for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                if (ld_hit[s][p]) begin
                    slot_ctl[s].ld   = 1'b1;
                    slot_ctl[s].port = PORT_W'(p);
                end
            end

            slot_ctl[s].mark = |mark_hit[s];

            // a mark in the same cycle takes precedence over writeback
            slot_ctl[s].tag_clr = wb.valid
                                  && (wb.tag == slot_tag[s])
                                  && !slot_ctl[s].mark;

            // flush overrides every request
            if (clr) begin
                slot_ctl[s] = '0;
            end
        end
    end

    assign flush = clr;

endmodule

/* design/seg_slot.sv */
`include "seg_consts.svh"

module seg_slot
    import seg_types_pkg::*,
           seg_port_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        flush,
    input  seg_slot_ctl_t                               ctl,
    input  logic [`SEG_NUM_PORTS-1:0][`SEG_BASE_W-1:0]  ld_base,
    input  logic [`SEG_LIM_W-1:0]                       lim_init,
    input  logic [`SEG_TAG_W-1:0]                       new_tag,
    output seg_state_t                                  state
);

    logic [`SEG_BASE_W-1:0] base_d;

    // base from the winning load port
    assign base_d = ld_base[ctl.port];

    ////////////////////
    // slot registers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '0;
        end else if (flush) begin
            state.base    <= '0;
            state.limit   <= lim_init;
            state.tag     <= '0;
            state.pending <= 1'b0;
        end else begin
            if (ctl.ld) begin
                state.base <= base_d;
            end

            // new destination, or its result has come back
            if (ctl.mark) begin
                state.tag     <= new_tag;
                state.pending <= 1'b1;
            end else if (ctl.tag_clr) begin
                state.pending <= 1'b0;
            end
        end
    end

endmodule

/* design/seg_read_mux.sv */
`include "seg_consts.svh"

module seg_read_mux
    import seg_types_pkg::*;
(
    input  logic [`SEG_ADDR_W-1:0]          rd_addr,
    input  seg_state_t [`SEG_NUM_SLOTS-1:0] slots,
    output seg_rd_t                         rd
);

    seg_state_t sel;

    // codes past the last slot read as zero
    always_comb begin
        sel = '0;
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            if (rd_addr == `SEG_ADDR_W'(s)) begin
                sel = slots[s];
            end
        end
    end

    ////////////////////
    // read result
    ////////////////////

    always_comb begin
        rd.base    = sel.base;
        rd.limit   = sel.limit;
        rd.tag     = sel.tag;
        rd.pending = sel.pending;
    end

endmodule

/* design/seg_file_top.sv */
`include "seg_consts.svh"

module seg_file_top
    import seg_types_pkg::*,
           seg_port_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        clr,
    input  logic [`SEG_NUM_SLOTS-1:0][`SEG_LIM_W-1:0]  lim_init,
    input  seg_ld_req_t [`SEG_NUM_PORTS-1:0]            ld_req,
    input  logic [`SEG_NUM_PORTS-1:0][`SEG_ADDR_W-1:0]  rd_addr,
    input  logic [`SEG_NUM_PORTS-1:0]                   mark,
    input  logic [`SEG_TAG_W-1:0]                       new_tag,
    input  seg_wb_t                                     wb,
    output seg_rd_t [`SEG_NUM_PORTS-1:0]                rd_data
);

    seg_slot_ctl_t [`SEG_NUM_SLOTS-1:0]          slot_ctl;
    seg_state_t [`SEG_NUM_SLOTS-1:0]             slot_q;
    logic [`SEG_NUM_SLOTS-1:0][`SEG_TAG_W-1:0]  slot_tag;
    logic [`SEG_NUM_PORTS-1:0][`SEG_BASE_W-1:0] ld_base;
    logic                                        flush;

    seg_ctrl u_ctrl (
        .clr      (clr),
        .ld_req   (ld_req),
        .rd_addr  (rd_addr),
        .mark     (mark),
        .wb       (wb),
        .slot_tag (slot_tag),
        .slot_ctl (slot_ctl),
        .flush    (flush)
    );

    ////////////////////
    // slots
    ////////////////////

    for (genvar p = 0; p < `SEG_NUM_PORTS; p++) begin : g_base
        assign ld_base[p] = ld_req[p].base;
    end

    for (genvar s = 0; s < `SEG_NUM_SLOTS; s++) begin : g_slot
        seg_slot u_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .flush    (flush),
            .ctl      (slot_ctl[s]),
            .ld_base  (ld_base),
            .lim_init (lim_init[s]),
            .new_tag  (new_tag),
            .state    (slot_q[s])
        );

        // stored tags back to the writeback compare
        assign slot_tag[s] = slot_q[s].tag;
    end

    ////////////////////
    // read ports
    ////////////////////

    for (genvar p = 0; p < `SEG_NUM_PORTS; p++) begin : g_rd
        seg_read_mux u_rd (
            .rd_addr (rd_addr[p]),
            .slots   (slot_q),
            .rd      (rd_data[p])
        );
    end

endmodule

/* verif/seg_file_tb.sv */
`include "seg_consts.svh"

module seg_file_tb
    import seg_types_pkg::*,
           seg_port_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ADDR = 1 << `SEG_ADDR_W;
    // tests take a few hundred cycles, generous margin on top
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                        clk;
    logic                                        rst_n;
    logic                                        clr;
    logic [`SEG_NUM_SLOTS-1:0][`SEG_LIM_W-1:0]  lim_init;
    seg_ld_req_t [`SEG_NUM_PORTS-1:0]            ld_req;
    logic [`SEG_NUM_PORTS-1:0][`SEG_ADDR_W-1:0] rd_addr;
    logic [`SEG_NUM_PORTS-1:0]                   mark;
    logic [`SEG_TAG_W-1:0]                       new_tag;
    seg_wb_t                                     wb;
    seg_rd_t [`SEG_NUM_PORTS-1:0]                rd_data;

    // scoreboard of the slot contents
    logic [`SEG_BASE_W-1:0] exp_base [`SEG_NUM_SLOTS];
    logic [`SEG_LIM_W-1:0]  exp_lim  [`SEG_NUM_SLOTS];
    logic [`SEG_TAG_W-1:0]  exp_tag  [`SEG_NUM_SLOTS];
    logic                   exp_pend [`SEG_NUM_SLOTS];

    integer seed = 32'h3f09;
    int     cycle_cnt = 0;

    seg_file_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (clr),
        .lim_init (lim_init),
        .ld_req   (ld_req),
        .rd_addr  (rd_addr),
        .mark     (mark),
        .new_tag  (new_tag),
        .wb       (wb),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout, tests still running after %0d cycles", cycle_cnt));
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [`SEG_BASE_W-1:0] rand_base();
        logic [31:0] r;
        r = $random(seed);
        return r[`SEG_BASE_W-1:0];
    endfunction

    function automatic logic [`SEG_LIM_W-1:0] rand_lim();
        logic [31:0] r;
        r = $random(seed);
        return r[`SEG_LIM_W-1:0];
    endfunction

    function automatic logic [`SEG_TAG_W-1:0] rand_tag();
        logic [31:0] r;
        r = $random(seed);
        return r[`SEG_TAG_W-1:0];
    endfunction

    task automatic clear_inputs();
        clr     = 1'b0;
        ld_req  = '0;
        mark    = '0;
        new_tag = '0;
        wb      = '0;
    endtask

    task automatic drive_load(int p, int slot, logic valid);
        ld_req[p].valid = valid;
        ld_req[p].addr  = `SEG_ADDR_W'(slot);
        ld_req[p].base  = rand_base();
    endtask

    task automatic drive_mark(int p, int slot);
        rd_addr[p] = `SEG_ADDR_W'(slot);
        mark[p]    = 1'b1;
    endtask

    // next slot contents from the inputs now on the pins
    task automatic model_update();
        logic hit_mark;
        logic hit_wb;
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            hit_mark = 1'b0;
            for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                if (mark[p] && rd_addr[p] == `SEG_ADDR_W'(s)) begin
                    hit_mark = 1'b1;
                end
            end
            hit_wb = wb.valid && (wb.tag == exp_tag[s]);
            if (clr) begin
                exp_base[s] = '0;
                exp_lim[s]  = lim_init[s];
                exp_tag[s]  = '0;
                exp_pend[s] = 1'b0;
            end else begin
                // walk ports upward so the highest one is left standing
                for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                    if (ld_req[p].valid && ld_req[p].addr == `SEG_ADDR_W'(s)) begin
                        exp_base[s] = ld_req[p].base;
                    end
                end
                if (hit_mark) begin
                    exp_tag[s]  = new_tag;
                    exp_pend[s] = 1'b1;
                end else if (hit_wb) begin
                    exp_pend[s] = 1'b0;
                end
            end
        end
    endtask

    task automatic tick();
        model_update();
        @(posedge clk);
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic check_port(int p, int a);
        seg_rd_t want;
        want = '0;
        if (a < `SEG_NUM_SLOTS) begin
            want.base    = exp_base[a];
            want.limit   = exp_lim[a];
            want.tag     = exp_tag[a];
            want.pending = exp_pend[a];
        end
        assert (rd_data[p] === want) else begin
            report_error($sformatf("FAIL rd_data[%0d] addr %0d: got %h expected %h",
                                   p, a, rd_data[p], want));
        end
    endtask

    // every address on every port, one address set per cycle
    task automatic check_all();
        for (int a = 0; a < NUM_ADDR; a++) begin
            for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                rd_addr[p] = `SEG_ADDR_W'((a + p) % NUM_ADDR);
            end
            #1;
            for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
                check_port(p, (a + p) % NUM_ADDR);
            end
            @(negedge clk);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset_flush();
        check_all();
        clr = 1'b1;
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            lim_init[s] = rand_lim();
        end
        tick();
        check_all();
    endtask

    task automatic test_load_readback();
        for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
            drive_load(p, p, 1'b1);
        end
        tick();
        check_all();
        for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
            drive_load(p, (p + 4) % `SEG_NUM_SLOTS, 1'b1);
        end
        tick();
        check_all();
    endtask

    task automatic test_load_priority();
        drive_load(0, 2, 1'b1);
        drive_load(1, 2, 1'b1);
        drive_load(2, 2, 1'b1);
        drive_load(3, 5, 1'b1);
        tick();
        check_all();
        drive_load(0, 0, 1'b0);
        drive_load(1, 0, 1'b1);
        drive_load(2, 0, 1'b0);
        drive_load(3, 0, 1'b1);
        tick();
        check_all();
        // nothing valid, nothing stored
        for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
            drive_load(p, 3, 1'b0);
        end
        tick();
        check_all();
    endtask

    task automatic test_pending_tags();
        logic [`SEG_TAG_W-1:0] tag_a;
        logic [`SEG_TAG_W-1:0] tag_b;
        tag_a = rand_tag();
        tag_b = tag_a ^ `SEG_TAG_W'(5);
        new_tag = tag_a;
        drive_mark(2, 1);
        tick();
        check_all();
        wb.valid = 1'b1;
        wb.tag   = ~tag_a;
        tick();
        check_all();
        wb.valid = 1'b1;
        wb.tag   = tag_a;
        tick();
        check_all();
        // mark and matching writeback together
        new_tag = tag_b;
        drive_mark(0, 1);
        wb.valid = 1'b1;
        wb.tag   = tag_a;
        tick();
        check_all();
        new_tag = ~tag_b;
        drive_mark(1, 3);
        drive_mark(3, 4);
        tick();
        check_all();
        wb.valid = 1'b1;
        wb.tag   = ~tag_b;
        tick();
        check_all();
    endtask

    task automatic test_flush_live();
        for (int p = 0; p < `SEG_NUM_PORTS; p++) begin
            drive_load(p, p + 2, 1'b1);
        end
        new_tag = rand_tag();
        drive_mark(1, 0);
        drive_mark(2, 5);
        tick();
        check_all();
        // flush with competing requests in the same cycle
        clr = 1'b1;
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            lim_init[s] = rand_lim();
        end
        drive_load(3, 1, 1'b1);
        new_tag = rand_tag();
        drive_mark(0, 2);
        tick();
        check_all();
    endtask

    initial begin
        rst_n    = 1'b0;
        lim_init = '0;
        rd_addr  = '0;
        clear_inputs();
        for (int s = 0; s < `SEG_NUM_SLOTS; s++) begin
            exp_base[s] = '0;
            exp_lim[s]  = '0;
            exp_tag[s]  = '0;
            exp_pend[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_flush();
        test_load_readback();
        test_load_priority();
        test_pending_tags();
        test_flush_live();

        $display("Test passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/seg_types_pkg.sv
design/seg_port_pkg.sv
design/seg_ctrl.sv
design/seg_slot.sv
design/seg_read_mux.sv
design/seg_file_top.sv
verif/seg_file_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

# compile RTL and testbench into one simulator binary
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module seg_file_tb -o seg_file_sim

out=$(./obj_dir/seg_file_sim || true)
echo "$out"

if echo "$out" | grep -q "Test passed"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
